/* rtl/rv32i_slice_pkg.sv */
// shared types for the RV32I ALU slice; only OP, OP-IMM and LUI are decoded
// any other opcode value falls through to the NOP control packet
package rv32i_slice_pkg;

    localparam int xlen = 32;
    localparam int shamt_w = 5;

    typedef logic [4:0]      reg_addr_t;
    typedef logic [xlen-1:0] word_t;

    // base opcodes, only the first three reach the datapath
    typedef enum logic [6:0] {
        op_reg   = 7'b0110011,
        op_imm   = 7'b0010011,
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011
    } opcode_t;

    // funct3 encodings shared by OP and OP-IMM
    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_sll     = 3'b001;
    localparam logic [2:0] f3_slt     = 3'b010;
    localparam logic [2:0] f3_sltu    = 3'b011;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_shr     = 3'b101;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and
    } alu_op_t;

    // ------------------------------
    // instruction word views
    // ------------------------------
    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        opcode_t    opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0] imm12;
        reg_addr_t   rs1;
        logic [2:0]  funct3;
        reg_addr_t   rd;
        opcode_t     opcode;
    } i_type_t;

    typedef struct packed {
        logic [19:0] imm20;
        reg_addr_t   rd;
        opcode_t     opcode;
    } u_type_t;

    // the opcode sits in the same bits in every view
    typedef union packed {
        r_type_t r;
        i_type_t i;
        u_type_t u;
    } rv32i_inst_t;

    // control packet carried from decode into execute
    typedef struct packed {
        alu_op_t   alu_op;
        logic      use_imm;
        logic      is_lui;
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
        word_t     imm;
    } ctrl_pkt_t;

    localparam ctrl_pkt_t nop_ctrl = '{
        alu_op:  alu_add,
        use_imm: 1'b0,
        is_lui:  1'b0,
        rd:      '0,
        rs1:     '0,
        rs2:     '0,
        imm:     '0
    };

endpackage

/* rtl/stage_if.sv */
// stage-to-stage bundles; every valid is a one-cycle strobe with no ready
`timescale 1ns/1ps

// decode to execute: control packet plus the operands read from the register file
interface dec_ex_if;
    import rv32i_slice_pkg::*;

    logic      valid;
    ctrl_pkt_t ctrl;
    word_t     rs1_val;
    word_t     rs2_val;

    modport producer (
        output valid,
        output ctrl,
        output rs1_val,
        output rs2_val
    );

    modport consumer (
        input valid,
        input ctrl,
        input rs1_val,
        input rs2_val
    );

endinterface

// execute to result: destination and computed value
interface ex_res_if;
    import rv32i_slice_pkg::*;

    logic      valid;
    reg_addr_t rd;
    word_t     result;

    modport producer (
        output valid,
        output rd,
        output result
    );

    modport consumer (
        input valid,
        input rd,
        input result
    );

endinterface

/* rtl/instr_decode.sv */
// register reads are combinational in the strobe cycle, the packet is registered
// unknown opcodes become a NOP with rd 0
`timescale 1ns/1ps

module instr_decode (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      inst_valid,
    input  rv32i_slice_pkg::word_t    inst,
    output rv32i_slice_pkg::reg_addr_t rs1,
    output rv32i_slice_pkg::reg_addr_t rs2,
    input  rv32i_slice_pkg::word_t    rs1_val,
    input  rv32i_slice_pkg::word_t    rs2_val,
    dec_ex_if.producer                dec
);
    import rv32i_slice_pkg::*;

    rv32i_inst_t inst_u;
    ctrl_pkt_t   ctrl_d;

    // alt selects SUB or SRA; the I-type forms only allow it on shifts
    function automatic alu_op_t decode_alu_op(
        input logic [2:0] funct3,
        input logic       alt,
        input logic       sub_ok
    );
        alu_op_t op;
        case (funct3)
            f3_add_sub: op = (alt && sub_ok) ? alu_sub : alu_add;
            f3_sll:     op = alu_sll;
            f3_slt:     op = alu_slt;
            f3_sltu:    op = alu_sltu;
            f3_xor:     op = alu_xor;
            f3_shr:     op = alt ? alu_sra : alu_srl;
            f3_or:      op = alu_or;
            default:    op = alu_and;
        endcase
        return op;
    endfunction

    assign inst_u = inst;

    // ------------------------------
    // control decode
    // ------------------------------
    always_comb begin
        ctrl_d = nop_ctrl;
        case (inst_u.r.opcode)
            op_reg: begin
                ctrl_d.rd     = inst_u.r.rd;
                ctrl_d.rs1    = inst_u.r.rs1;
                ctrl_d.rs2    = inst_u.r.rs2;
                ctrl_d.alu_op = decode_alu_op(inst_u.r.funct3, inst_u.r.funct7[5], 1'b1);
            end
            op_imm: begin
                ctrl_d.rd      = inst_u.i.rd;
                ctrl_d.rs1     = inst_u.i.rs1;
                ctrl_d.use_imm = 1'b1;
                ctrl_d.imm     = {{(xlen-12){inst_u.i.imm12[11]}}, inst_u.i.imm12};
                // imm12[10] is funct7[5] for the shift-immediate forms
                ctrl_d.alu_op  = decode_alu_op(inst_u.i.funct3, inst_u.i.imm12[10], 1'b0);
            end
            op_lui: begin
                ctrl_d.rd     = inst_u.u.rd;
                ctrl_d.is_lui = 1'b1;
                ctrl_d.imm    = {inst_u.u.imm20, 12'b0};
            end
            default: ctrl_d = nop_ctrl;
        endcase
    end

    assign rs1 = ctrl_d.rs1;
    assign rs2 = ctrl_d.rs2;

    always_ff @(posedge clk) begin
        if (reset) begin
            dec.valid <= 1'b0;
        end else begin
            dec.valid <= inst_valid;
        end
    end

    always_ff @(posedge clk) begin
        dec.ctrl    <= ctrl_d;
        dec.rs1_val <= rs1_val;
        dec.rs2_val <= rs2_val;
    end

endmodule

/* rtl/alu_execute.sv */
// forwarding covers the two older instructions; rd 0 never forwards
`timescale 1ns/1ps

module alu_execute (
    input  logic                       clk,
    input  logic                       reset,
    dec_ex_if.consumer                 dec,
    input  rv32i_slice_pkg::reg_addr_t fwd_rd,
    input  rv32i_slice_pkg::word_t     fwd_data,
    input  logic                       fwd_valid,
    ex_res_if.producer                 ex
);
    import rv32i_slice_pkg::*;

    word_t op_a;
    word_t op_b;
    word_t rs2_fwd;
    word_t alu_out;
    logic [shamt_w-1:0] shamt;

    // newest value wins: execute register, then retire register, then the read value
    function automatic word_t pick_operand(
        input reg_addr_t src,
        input word_t     read_val,
        input logic      ex_ok,
        input reg_addr_t ex_rd,
        input word_t     ex_val,
        input logic      wb_ok,
        input reg_addr_t wb_rd,
        input word_t     wb_val
    );
        word_t sel;
        sel = read_val;
        if (src != '0) begin
            if (ex_ok && ex_rd == src) begin
                sel = ex_val;
            end else if (wb_ok && wb_rd == src) begin
                sel = wb_val;
            end
        end
        return sel;
    endfunction

    // ------------------------------
    // operand select
    // ------------------------------
    assign op_a = pick_operand(dec.ctrl.rs1, dec.rs1_val, ex.valid, ex.rd, ex.result,
                               fwd_valid, fwd_rd, fwd_data);
    assign rs2_fwd = pick_operand(dec.ctrl.rs2, dec.rs2_val, ex.valid, ex.rd, ex.result,
                                  fwd_valid, fwd_rd, fwd_data);
    assign op_b = dec.ctrl.use_imm ? dec.ctrl.imm : rs2_fwd;

    assign shamt = op_b[shamt_w-1:0];

    always_comb begin
        if (dec.ctrl.is_lui) begin
            alu_out = dec.ctrl.imm;
        end else begin
            case (dec.ctrl.alu_op)
                alu_add:  alu_out = op_a + op_b;
                alu_sub:  alu_out = op_a - op_b;
                alu_sll:  alu_out = op_a << shamt;
                alu_slt:  alu_out = word_t'($signed(op_a) < $signed(op_b));
                alu_sltu: alu_out = word_t'(op_a < op_b);
                alu_xor:  alu_out = op_a ^ op_b;
                alu_srl:  alu_out = op_a >> shamt;
                alu_sra:  alu_out = word_t'($signed(op_a) >>> shamt);
                alu_or:   alu_out = op_a | op_b;
                alu_and:  alu_out = op_a & op_b;
                default:  alu_out = '0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ex.valid <= 1'b0;
        end else begin
            ex.valid <= dec.valid;
        end
    end

    always_ff @(posedge clk) begin
        ex.rd     <= dec.ctrl.rd;
        ex.result <= alu_out;
    end

endmodule

/* rtl/result_regfile.sv */
// x0 is not stored and reads as zero; reads see a write in the same cycle
`timescale 1ns/1ps

module result_regfile (
    input  logic                       clk,
    input  logic                       reset,
    ex_res_if.consumer                 ex,
    input  rv32i_slice_pkg::reg_addr_t rs1,
    input  rv32i_slice_pkg::reg_addr_t rs2,
    output rv32i_slice_pkg::word_t     rs1_val,
    output rv32i_slice_pkg::word_t     rs2_val,
    output logic                       retire_valid,
    output rv32i_slice_pkg::reg_addr_t retire_rd,
    output rv32i_slice_pkg::word_t     retire_data
);
    import rv32i_slice_pkg::*;

    word_t regs [1:31];
    logic  wr_en;

    assign wr_en = ex.valid && (ex.rd != '0);

    // ------------------------------
    // read ports with write bypass
    // ------------------------------
    assign rs1_val = (rs1 == '0) ? '0 : (wr_en && ex.rd == rs1) ? ex.result : regs[rs1];
    assign rs2_val = (rs2 == '0) ? '0 : (wr_en && ex.rd == rs2) ? ex.result : regs[rs2];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[ex.rd] <= ex.result;
        end
    end

    // the retire registers double as the older forwarding source
    always_ff @(posedge clk) begin
        if (reset) begin
            retire_valid <= 1'b0;
            retire_rd    <= '0;
            retire_data  <= '0;
        end else begin
            retire_valid <= ex.valid;
            retire_rd    <= ex.rd;
            retire_data  <= ex.result;
        end
    end

endmodule

/* rtl/rv32i_slice.sv */
// retire follows inst_valid by exactly three cycles; there is no back-pressure
`timescale 1ns/1ps

module rv32i_slice (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       inst_valid,
    input  rv32i_slice_pkg::word_t     inst,
    output logic                       retire_valid,
    output rv32i_slice_pkg::reg_addr_t retire_rd,
    output rv32i_slice_pkg::word_t     retire_data
);
    import rv32i_slice_pkg::*;

    reg_addr_t rs1;
    reg_addr_t rs2;
    word_t     rs1_val;
    word_t     rs2_val;

    dec_ex_if dec_ex ();
    ex_res_if ex_res ();

    instr_decode i_decode (
        .clk        (clk),
        .reset      (reset),
        .inst_valid (inst_valid),
        .inst       (inst),
        .rs1        (rs1),
        .rs2        (rs2),
        .rs1_val    (rs1_val),
        .rs2_val    (rs2_val),
        .dec        (dec_ex.producer)
    );

    // retire outputs loop back as the second forwarding source
    alu_execute i_execute (
        .clk       (clk),
        .reset     (reset),
        .dec       (dec_ex.consumer),
        .fwd_rd    (retire_rd),
        .fwd_data  (retire_data),
        .fwd_valid (retire_valid),
        .ex        (ex_res.producer)
    );

    result_regfile i_result (
        .clk          (clk),
        .reset        (reset),
        .ex           (ex_res.consumer),
        .rs1          (rs1),
        .rs2          (rs2),
        .rs1_val      (rs1_val),
        .rs2_val      (rs2_val),
        .retire_valid (retire_valid),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data)
    );

endmodule

/* dv/tb_clock_gen.sv */
// free-running clock, starts low at time zero
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter real period_ns = 4.0
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always #(period_ns / 2.0) clk = ~clk;

endmodule

/* dv/tb_checker.sv */
// compares every retire with the oldest pending expectation, in issue order
// expectations must be queued before the edge that samples their inst_valid
`timescale 1ns/1ps

module tb_checker (
    input  logic        clk,
    input  logic        reset,
    input  logic        inst_valid,
    input  logic        retire_valid,
    input  logic [4:0]  retire_rd,
    input  logic [31:0] retire_data,
    output int          pass_count,
    output int          fail_count,
    output int          pending
);

    string       exp_name [$];
    logic [4:0]  exp_rd [$];
    logic [31:0] exp_data [$];
    int          issue_cycle [$];
    int          cycle;

    task automatic expect_result(input string name, input logic [4:0] rd,
                                 input logic [31:0] data);
        exp_name.push_back(name);
        exp_rd.push_back(rd);
        exp_data.push_back(data);
    endtask

    task automatic check_retire();
        string       name;
        logic [4:0]  rd;
        logic [31:0] data;
        int          issued;
        bit          ok;
        if (exp_name.size() == 0 || issue_cycle.size() == 0) begin
            $display("t=%0t: retire_valid was high with no result pending (rd %0d)",
                     $time, retire_rd);
            fail_count++;
        end else begin
            name   = exp_name.pop_front();
            rd     = exp_rd.pop_front();
            data   = exp_data.pop_front();
            issued = issue_cycle.pop_front();
            ok     = 1'b1;
            if (retire_rd !== rd) begin
                $display("ERROR t=%0t retire_rd expected %0d got %0d", $time, rd, retire_rd);
                ok = 1'b0;
            end
            if (retire_data !== data) begin
                $display("ERROR t=%0t retire_data expected %h got %h",
                         $time, data, retire_data);
                ok = 1'b0;
            end
            // fixed three-stage latency from the sampled strobe
            if (cycle != issued + 3) begin
                $display("%s retired %0d cycles after issue instead of 3", name, cycle - issued);
                ok = 1'b0;
            end
            if (ok) begin
                pass_count++;
                $display("test %-12s passed  rd=%0d data=%h", name, retire_rd, retire_data);
            end else begin
                fail_count++;
                $display("test %-12s failed", name);
            end
        end
    endtask

    always @(posedge clk) begin
        if (reset) begin
            cycle      = 0;
            pass_count = 0;
            fail_count = 0;
        end else begin
            cycle++;
            if (retire_valid) begin
                check_retire();
            end
            if (inst_valid) begin
                issue_cycle.push_back(cycle);
            end
        end
        pending = exp_name.size();
    end

endmodule

/* dv/tb_rv32i_slice.sv */
// drives a table of ALU instructions and queues golden results for the checker
// the golden model assumes in-order issue with no stalls
`timescale 1ns/1ps

module tb_rv32i_slice;

    logic        clk;
    logic        reset;
    logic        inst_valid;
    logic [31:0] inst;
    logic        retire_valid;
    logic [4:0]  retire_rd;
    logic [31:0] retire_data;
    int          pass_count;
    int          fail_count;
    int          pending;

    logic [31:0] tbl_inst [$];
    int          tbl_gap [$];
    string       tbl_name [$];
    logic [31:0] model_regs [0:31];
    int          cycle_limit;
    int          cycle_count;

    tb_clock_gen #(.period_ns(4.0)) i_clk (.clk(clk));

    rv32i_slice i_dut (
        .clk          (clk),
        .reset        (reset),
        .inst_valid   (inst_valid),
        .inst         (inst),
        .retire_valid (retire_valid),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data)
    );

    tb_checker i_checker (
        .clk          (clk),
        .reset        (reset),
        .inst_valid   (inst_valid),
        .retire_valid (retire_valid),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data),
        .pass_count   (pass_count),
        .fail_count   (fail_count),
        .pending      (pending)
    );

    // ------------------------------
    // instruction encoders
    // ------------------------------
    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, 7'b0110111};
    endfunction

    task automatic add_row(input logic [31:0] word, input int gap, input string name);
        tbl_inst.push_back(word);
        tbl_gap.push_back(gap);
        tbl_name.push_back(name);
    endtask

    // reference behavior of one instruction, straight from the RV32I rules
    function automatic void model_step(input logic [31:0] w, output logic [4:0] rd,
                                       output logic [31:0] val);
        logic [6:0]  opc;
        logic [2:0]  f3;
        logic        alt;
        logic [31:0] a;
        logic [31:0] b;
        opc = w[6:0];
        f3  = w[14:12];
        rd  = w[11:7];
        a   = model_regs[w[19:15]];
        b   = model_regs[w[24:20]];
        alt = w[30];
        val = '0;
        if (opc == 7'b0110111) begin
            val = {w[31:12], 12'b0};
        end else if (opc == 7'b0110011 || opc == 7'b0010011) begin
            if (opc == 7'b0010011) begin
                b   = {{20{w[31]}}, w[31:20]};
                // only the right shift has an alternate immediate form
                alt = alt && (f3 == 3'b101);
            end
            case (f3)
                3'b000: val = alt ? a - b : a + b;
                3'b001: val = a << b[4:0];
                3'b010: val = {31'b0, $signed(a) < $signed(b)};
                3'b011: val = {31'b0, a < b};
                3'b100: val = a ^ b;
                3'b101: begin
                    if (alt) begin
                        val = $signed(a) >>> b[4:0];
                    end else begin
                        val = a >> b[4:0];
                    end
                end
                3'b110: val = a | b;
                default: val = a & b;
            endcase
        end else begin
            rd = '0;
        end
        if (rd != '0) begin
            model_regs[rd] = val;
        end
    endfunction

    task automatic build_table();
        logic [31:0] rnd;
        rnd = $urandom();
        add_row(enc_i(-12'sd5, 5'd0, 3'b000, 5'd1), 0, "addi_neg");
        add_row(enc_i(12'd100, 5'd0, 3'b000, 5'd2), 2, "addi_pos");
        add_row(enc_i(-12'sd4, 5'd2, 3'b010, 5'd3), 1, "slti");
        add_row(enc_i(12'd5, 5'd1, 3'b011, 5'd4), 0, "sltiu");
        add_row(enc_i(12'h0f0, 5'd2, 3'b100, 5'd5), 1, "xori");
        add_row(enc_i(12'h100, 5'd2, 3'b110, 5'd6), 0, "ori");
        add_row(enc_i(12'h0f0, 5'd2, 3'b111, 5'd7), 0, "andi");
        add_row(enc_i(12'd4, 5'd2, 3'b001, 5'd8), 1, "slli");
        add_row(enc_i(12'd28, 5'd1, 3'b101, 5'd9), 0, "srli");
        add_row(enc_i(12'h401, 5'd1, 3'b101, 5'd10), 0, "srai");
        add_row(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd11), 3, "add");
        add_row(enc_r(7'h20, 5'd2, 5'd1, 3'b000, 5'd12), 0, "sub");
        add_row(enc_r(7'h00, 5'd9, 5'd2, 3'b001, 5'd13), 1, "sll");
        add_row(enc_r(7'h00, 5'd2, 5'd1, 3'b011, 5'd14), 0, "sltu");
        add_row(enc_r(7'h00, 5'd2, 5'd1, 3'b010, 5'd19), 0, "slt");
        add_row(enc_r(7'h00, 5'd2, 5'd1, 3'b100, 5'd29), 0, "xor");
        add_row(enc_r(7'h00, 5'd9, 5'd2, 3'b110, 5'd30), 0, "or");
        add_row(enc_r(7'h00, 5'd9, 5'd1, 3'b101, 5'd15), 2, "srl");
        add_row(enc_r(7'h20, 5'd9, 5'd1, 3'b101, 5'd16), 0, "sra");
        add_row(enc_r(7'h00, 5'd6, 5'd1, 3'b111, 5'd17), 0, "and");
        add_row(enc_u(20'habcde, 5'd18), 1, "lui");
        // back to back from here: distances 1, 2 and 3 to the producer
        add_row(enc_i(12'd1, 5'd18, 3'b000, 5'd20), 0, "fwd_dist1");
        add_row(enc_i(12'd7, 5'd0, 3'b000, 5'd21), 0, "fwd_load");
        add_row(enc_r(7'h00, 5'd21, 5'd20, 3'b000, 5'd22), 0, "fwd_dist2");
        add_row(enc_i(-12'sd1, 5'd20, 3'b000, 5'd23), 0, "fwd_dist3");
        // x23 written twice in a row, the reader must see the newer value
        add_row(enc_i(12'd16, 5'd23, 3'b000, 5'd23), 0, "fwd_same_rd");
        add_row(enc_r(7'h00, 5'd0, 5'd23, 3'b000, 5'd28), 0, "fwd_newest");
        add_row(enc_i(12'd55, 5'd2, 3'b000, 5'd0), 2, "write_x0");
        add_row(enc_r(7'h00, 5'd2, 5'd0, 3'b000, 5'd24), 0, "read_x0");
        add_row(32'hdead_b07f, 1, "unknown_op");
        add_row(enc_u(rnd[31:12], 5'd25), 1, "rand_lui");
        add_row(enc_i(rnd[11:0], 5'd25, 3'b100, 5'd26), 0, "rand_xori");
        add_row(enc_r(7'h20, 5'd1, 5'd26, 3'b000, 5'd27), 0, "rand_sub");
    endtask

    initial begin
        logic [4:0]  exp_rd;
        logic [31:0] exp_data;
        reset       = 1'b1;
        inst_valid  = 1'b0;
        inst        = '0;
        cycle_limit = 0;
        void'($urandom(3));
        for (int r = 0; r < 32; r++) begin
            model_regs[r] = '0;
        end
        build_table();
        cycle_limit = 10 + 20;
        foreach (tbl_gap[i]) begin
            cycle_limit += tbl_gap[i] + 1;
        end

        repeat (10) @(posedge clk);
        #0.5 reset = 1'b0;

        foreach (tbl_inst[i]) begin
            repeat (tbl_gap[i]) begin
                @(posedge clk);
                #0.5 inst_valid = 1'b0;
            end
            @(posedge clk);
            #0.5;
            inst_valid = 1'b1;
            inst       = tbl_inst[i];
            model_step(tbl_inst[i], exp_rd, exp_data);
            i_checker.expect_result(tbl_name[i], exp_rd, exp_data);
        end
        @(posedge clk);
        #0.5 inst_valid = 1'b0;

        wait (pending == 0);
        // a few idle cycles to catch a stray retire
        repeat (5) @(posedge clk);
        $display("summary: %0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0 && pending == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    // ------------------------------
    // timeout
    // ------------------------------
    initial begin
        cycle_count = 0;
        wait (cycle_limit > 0);
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: run did not finish within %0d cycles, %0d results still pending",
                 cycle_limit, pending);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

/* rv32i_slice.f */
rtl/rv32i_slice_pkg.sv
rtl/stage_if.sv
rtl/instr_decode.sv
rtl/alu_execute.sv
rtl/result_regfile.sv
rtl/rv32i_slice.sv
dv/tb_clock_gen.sv
dv/tb_checker.sv
dv/tb_rv32i_slice.sv

/* Bender.yml */
package:
  name: rv32i_slice

sources:
  - rtl/rv32i_slice_pkg.sv
  - rtl/stage_if.sv
  - rtl/instr_decode.sv
  - rtl/alu_execute.sv
  - rtl/result_regfile.sv
  - rtl/rv32i_slice.sv
  - target: simulation
    files:
      - dv/tb_clock_gen.sv
      - dv/tb_checker.sv
      - dv/tb_rv32i_slice.sv
